// File: leaf_params.svh
`ifndef LEAF_PARAMS_SVH
`define LEAF_PARAMS_SVH

// ####################
// Packet layout
// ####################

// Full network word, including the valid bit.
`define LEAF_PACKET_BITS 49

// Data word carried in a data packet.
`define LEAF_PAYLOAD_BITS 32

`define LEAF_NUM_LEAF_BITS 5  // Leaf address field.
`define LEAF_NUM_PORT_BITS 4  // Port address field.
`define LEAF_NUM_ADDR_BITS 7  // Address tag between header and payload.

// ####################
// Leaf sizes
// ####################

`define LEAF_NUM_IN_PORTS 2
`define LEAF_NUM_OUT_PORTS 2

// Default depth of each input port buffer, a power of two.
`define LEAF_FIFO_DEPTH 8

`endif

// File: leaf_pkg.sv
`default_nettype none

`include "leaf_params.svh"

package leaf_pkg;

    // Bits left over at the bottom of a config packet.
    localparam int CFG_RSVD_BITS = `LEAF_PACKET_BITS - 1 - 3 * `LEAF_NUM_PORT_BITS
                                 - 2 * `LEAF_NUM_LEAF_BITS - `LEAF_NUM_ADDR_BITS;

    // One entry of the output route table.
    typedef struct packed {
        logic [`LEAF_NUM_LEAF_BITS-1:0] leaf;
        logic [`LEAF_NUM_PORT_BITS-1:0] port;
    } route_t;

    typedef struct packed {
        logic                           valid;
        logic [`LEAF_NUM_LEAF_BITS-1:0] dst_leaf;
        logic [`LEAF_NUM_PORT_BITS-1:0] dst_port;
        logic [`LEAF_NUM_ADDR_BITS-1:0] tag;      // Ignored on receive, zero on send.
        logic [`LEAF_PAYLOAD_BITS-1:0]  payload;
    } bft_data_t;

    typedef struct packed {
        logic                           valid;
        logic [`LEAF_NUM_LEAF_BITS-1:0] dst_leaf;
        logic [`LEAF_NUM_PORT_BITS-1:0] dst_port;
        logic [`LEAF_NUM_ADDR_BITS-1:0] rsvd_hi;
        logic [`LEAF_NUM_PORT_BITS-1:0] out_port; // Output ports count from 1.
        route_t                         target;
        logic [CFG_RSVD_BITS-1:0]       rsvd_lo;
    } bft_cfg_t;

    // Port 0 packets use the config view, all others the data view.
    typedef union packed {
        bft_data_t data;
        bft_cfg_t  cfg;
    } bft_packet_u;

endpackage

`default_nettype wire

// File: leaf_rx_decoder.sv
`timescale 1ns/100ps
`default_nettype none

`include "leaf_params.svh"

module leaf_rx_decoder #(
    parameter logic [`LEAF_NUM_LEAF_BITS-1:0] LEAF_ID = 3
) (
    input  wire                             clk,
    input  wire                             arst_n,
    input  wire  [`LEAF_PACKET_BITS-1:0]    din_leaf_bft2interface,
    output logic                            cfg_wr,
    output logic [`LEAF_NUM_PORT_BITS-1:0]  cfg_port,
    output leaf_pkg::route_t                cfg_route,
    output logic                            wr_1,
    output logic                            wr_2,
    output logic [`LEAF_PAYLOAD_BITS-1:0]   wr_data
);

    leaf_pkg::bft_packet_u pkt;
    logic                  for_me;
    logic                  is_cfg;
    logic                  is_port_1;
    logic                  is_port_2;

    assign pkt = din_leaf_bft2interface;

    // Valid and addressed to this leaf; the rest of the network traffic passes by.
    assign for_me = pkt.data.valid && (pkt.data.dst_leaf == LEAF_ID);

    assign is_cfg    = for_me && (pkt.data.dst_port == `LEAF_NUM_PORT_BITS'(0));
    assign is_port_1 = for_me && (pkt.data.dst_port == `LEAF_NUM_PORT_BITS'(1));
    assign is_port_2 = for_me && (pkt.data.dst_port == `LEAF_NUM_PORT_BITS'(2));

    // ####################
    // Strobes
    // ####################

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cfg_wr <= 1'b0;
            wr_1   <= 1'b0;
            wr_2   <= 1'b0;
        end else begin
            cfg_wr <= is_cfg;
            wr_1   <= is_port_1;
            wr_2   <= is_port_2;
        end
    end

    // Config and data fields are taken from every input word.
    always_ff @(posedge clk) begin
        cfg_port  <= pkt.cfg.out_port;
        cfg_route <= pkt.cfg.target;
        wr_data   <= pkt.data.payload;
    end

    // Each packet addresses exactly one input port buffer.
    a_one_port_write: assert property (
        @(posedge clk) disable iff (!arst_n)
        wr_1 |-> !wr_2
    ) else $error("leaf_rx_decoder: wr_1 and wr_2 high together");

endmodule

`default_nettype wire

// File: leaf_port_fifo.sv
`timescale 1ns/100ps
`default_nettype none

`include "leaf_params.svh"

module leaf_port_fifo #(
    parameter int DEPTH = `LEAF_FIFO_DEPTH
) (
    input  wire                            clk,
    input  wire                            arst_n,
    input  wire                            wr,
    input  wire  [`LEAF_PAYLOAD_BITS-1:0]  din,
    input  wire                            ack,
    output logic [`LEAF_PAYLOAD_BITS-1:0]  dout,
    output logic                           vld
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = PTR_W + 1;

    logic [`LEAF_PAYLOAD_BITS-1:0] mem [DEPTH];
    logic [PTR_W-1:0]              wr_ptr;
    logic [PTR_W-1:0]              rd_ptr;
    logic [CNT_W-1:0]              count;
    logic                          full;
    logic                          push;
    logic                          pop;

    assign full = (count == CNT_W'(DEPTH));
    assign push = wr && !full;              // A write into a full buffer is lost.
    assign pop  = ack && vld;

    // The head word is on dout whenever something is stored.
    assign dout = mem[rd_ptr];
    assign vld  = (count != '0);

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= din;
        end
    end

    // Pointers wrap by themselves since DEPTH is a power of two.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // The decoder has no view of the fill level, so overflow means lost data.
    a_no_overflow: assert property (
        @(posedge clk) disable iff (!arst_n)
        wr |-> !full
    ) else $error("leaf_port_fifo: write while full, word dropped");

    // The kernel only takes a word that is on offer.
    a_no_underflow: assert property (
        @(posedge clk) disable iff (!arst_n)
        ack |-> vld
    ) else $error("leaf_port_fifo: ack while empty");

endmodule

`default_nettype wire

// File: leaf_user_kernel.sv
`timescale 1ns/100ps
`default_nettype none

`include "leaf_params.svh"

module leaf_user_kernel (
    input  wire                            clk,
    input  wire                            arst_n,
    input  wire  [`LEAF_PAYLOAD_BITS-1:0]  dout_leaf_interface2user_1,
    input  wire  [`LEAF_PAYLOAD_BITS-1:0]  dout_leaf_interface2user_2,
    input  wire                            vld_interface2user_1,
    input  wire                            vld_interface2user_2,
    input  wire                            ack_interface2user_1,
    input  wire                            ack_interface2user_2,
    output logic                           ack_user2interface_1,
    output logic                           ack_user2interface_2,
    output logic [`LEAF_PAYLOAD_BITS-1:0]  din_leaf_user2interface_1,
    output logic [`LEAF_PAYLOAD_BITS-1:0]  din_leaf_user2interface_2,
    output logic                           vld_user2interface_1,
    output logic                           vld_user2interface_2
);

    logic take;

    // A new pair is taken only once both results of the last pair have left.
    assign take = vld_interface2user_1 && vld_interface2user_2
               && !vld_user2interface_1 && !vld_user2interface_2;

    assign ack_user2interface_1 = take;
    assign ack_user2interface_2 = take;

    always_ff @(posedge clk) begin
        if (take) begin
            din_leaf_user2interface_1 <= dout_leaf_interface2user_1 + dout_leaf_interface2user_2;
            din_leaf_user2interface_2 <= dout_leaf_interface2user_1 - dout_leaf_interface2user_2;
        end
    end

    // Each result is released by its own acknowledge.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            vld_user2interface_1 <= 1'b0;
            vld_user2interface_2 <= 1'b0;
        end else if (take) begin
            vld_user2interface_1 <= 1'b1;
            vld_user2interface_2 <= 1'b1;
        end else begin
            if (ack_interface2user_1) vld_user2interface_1 <= 1'b0;
            if (ack_interface2user_2) vld_user2interface_2 <= 1'b0;
        end
    end

    a_hold_out_1: assert property (
        @(posedge clk) disable iff (!arst_n)
        vld_user2interface_1 && !ack_interface2user_1 |=> $stable(din_leaf_user2interface_1)
    ) else $error("leaf_user_kernel: output 1 changed before its ack");

    a_hold_out_2: assert property (
        @(posedge clk) disable iff (!arst_n)
        vld_user2interface_2 && !ack_interface2user_2 |=> $stable(din_leaf_user2interface_2)
    ) else $error("leaf_user_kernel: output 2 changed before its ack");

endmodule

`default_nettype wire

// File: leaf_tx_packetizer.sv
`timescale 1ns/100ps
`default_nettype none

`include "leaf_params.svh"

module leaf_tx_packetizer (
    input  wire                             clk,
    input  wire                             arst_n,
    input  wire                             resend,
    input  wire                             cfg_wr,
    input  wire  [`LEAF_NUM_PORT_BITS-1:0]  cfg_port,
    input  leaf_pkg::route_t                cfg_route,
    input  wire  [`LEAF_PAYLOAD_BITS-1:0]   din_leaf_user2interface_1,
    input  wire  [`LEAF_PAYLOAD_BITS-1:0]   din_leaf_user2interface_2,
    input  wire                             vld_user2interface_1,
    input  wire                             vld_user2interface_2,
    output logic                            ack_interface2user_1,
    output logic                            ack_interface2user_2,
    output logic [`LEAF_PACKET_BITS-1:0]    dout_leaf_interface2bft
);

    leaf_pkg::route_t      route_tbl [`LEAF_NUM_OUT_PORTS];
    logic                  rr_q;     // 0 gives port 1 priority, 1 gives port 2.
    logic                  pend_q;
    leaf_pkg::bft_packet_u pkt_q;
    leaf_pkg::bft_packet_u pkt_next;
    logic                  sel;

    // ####################
    // Route table
    // ####################

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `LEAF_NUM_OUT_PORTS; i++) begin
                route_tbl[i] <= '0;
            end
        end else if (cfg_wr) begin
            for (int i = 0; i < `LEAF_NUM_OUT_PORTS; i++) begin
                if (cfg_port == `LEAF_NUM_PORT_BITS'(i + 1)) route_tbl[i] <= cfg_route;
            end
        end
    end

    // ####################
    // Arbiter and packet
    // ####################

    assign ack_interface2user_1 = !resend && vld_user2interface_1
                               && (!rr_q || !vld_user2interface_2);
    assign ack_interface2user_2 = !resend && vld_user2interface_2
                               && (rr_q || !vld_user2interface_1);

    assign sel = ack_interface2user_2;

    always_comb begin
        pkt_next.data.valid    = 1'b1;
        pkt_next.data.dst_leaf = route_tbl[sel].leaf;
        pkt_next.data.dst_port = route_tbl[sel].port;
        pkt_next.data.tag      = '0;
        pkt_next.data.payload  = sel ? din_leaf_user2interface_2 : din_leaf_user2interface_1;
    end

    // A packet caught by resend waits in the register and goes out once resend drops.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rr_q   <= 1'b0;
            pend_q <= 1'b0;
        end else if (!resend) begin
            pend_q <= ack_interface2user_1 || ack_interface2user_2;
            if (ack_interface2user_1) rr_q <= 1'b1;
            else if (ack_interface2user_2) rr_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!resend) begin
            pkt_q <= pkt_next;
        end
    end

    assign dout_leaf_interface2bft = (pend_q && !resend) ? pkt_q : '0;

    a_ack_rules: assert property (
        @(posedge clk) disable iff (!arst_n)
        $onehot0({ack_interface2user_1, ack_interface2user_2})
            && !(resend && (ack_interface2user_1 || ack_interface2user_2))
    ) else $error("leaf_tx_packetizer: two acks, or an ack during resend");

endmodule

`default_nettype wire

// File: leaf_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "leaf_params.svh"

module leaf_top #(
    parameter logic [`LEAF_NUM_LEAF_BITS-1:0] LEAF_ID = 3
) (
    input  wire                           clk,
    input  wire                           arst_n,
    input  wire  [`LEAF_PACKET_BITS-1:0]  din_leaf_bft2interface,
    output logic [`LEAF_PACKET_BITS-1:0]  dout_leaf_interface2bft,
    input  wire                           resend
);

    logic                           cfg_wr;
    logic [`LEAF_NUM_PORT_BITS-1:0] cfg_port;
    leaf_pkg::route_t               cfg_route;
    logic                           wr_1, wr_2;
    logic [`LEAF_PAYLOAD_BITS-1:0]  wr_data;

    logic [`LEAF_PAYLOAD_BITS-1:0]  dout_leaf_interface2user_1, dout_leaf_interface2user_2;
    logic                           vld_interface2user_1, vld_interface2user_2;
    logic                           ack_user2interface_1, ack_user2interface_2;

    logic [`LEAF_PAYLOAD_BITS-1:0]  din_leaf_user2interface_1, din_leaf_user2interface_2;
    logic                           vld_user2interface_1, vld_user2interface_2;
    logic                           ack_interface2user_1, ack_interface2user_2;

    leaf_rx_decoder #(.LEAF_ID(LEAF_ID)) rx_decoder_inst (
        .clk(clk), .arst_n(arst_n),
        .din_leaf_bft2interface(din_leaf_bft2interface),
        .cfg_wr(cfg_wr), .cfg_port(cfg_port), .cfg_route(cfg_route),
        .wr_1(wr_1), .wr_2(wr_2), .wr_data(wr_data)
    );

    // Both input buffers share the decoder's data bus.
    leaf_port_fifo #(.DEPTH(`LEAF_FIFO_DEPTH)) port_fifo_1_inst (
        .clk(clk), .arst_n(arst_n), .wr(wr_1), .din(wr_data),
        .ack(ack_user2interface_1),
        .dout(dout_leaf_interface2user_1), .vld(vld_interface2user_1)
    );

    leaf_port_fifo #(.DEPTH(`LEAF_FIFO_DEPTH)) port_fifo_2_inst (
        .clk(clk), .arst_n(arst_n), .wr(wr_2), .din(wr_data),
        .ack(ack_user2interface_2),
        .dout(dout_leaf_interface2user_2), .vld(vld_interface2user_2)
    );

    leaf_user_kernel user_kernel_inst (
        .clk(clk), .arst_n(arst_n),
        .dout_leaf_interface2user_1(dout_leaf_interface2user_1),
        .dout_leaf_interface2user_2(dout_leaf_interface2user_2),
        .vld_interface2user_1(vld_interface2user_1),
        .vld_interface2user_2(vld_interface2user_2),
        .ack_interface2user_1(ack_interface2user_1),
        .ack_interface2user_2(ack_interface2user_2),
        .ack_user2interface_1(ack_user2interface_1),
        .ack_user2interface_2(ack_user2interface_2),
        .din_leaf_user2interface_1(din_leaf_user2interface_1),
        .din_leaf_user2interface_2(din_leaf_user2interface_2),
        .vld_user2interface_1(vld_user2interface_1),
        .vld_user2interface_2(vld_user2interface_2)
    );

    leaf_tx_packetizer tx_packetizer_inst (
        .clk(clk), .arst_n(arst_n), .resend(resend),
        .cfg_wr(cfg_wr), .cfg_port(cfg_port), .cfg_route(cfg_route),
        .din_leaf_user2interface_1(din_leaf_user2interface_1),
        .din_leaf_user2interface_2(din_leaf_user2interface_2),
        .vld_user2interface_1(vld_user2interface_1),
        .vld_user2interface_2(vld_user2interface_2),
        .ack_interface2user_1(ack_interface2user_1),
        .ack_interface2user_2(ack_interface2user_2),
        .dout_leaf_interface2bft(dout_leaf_interface2bft)
    );

endmodule

`default_nettype wire

// File: tb_leaf_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "leaf_params.svh"

module tb_leaf_top;

    localparam logic [`LEAF_NUM_LEAF_BITS-1:0] LEAF_ID = 5'd3;
    localparam int N_BASIC       = 12;  // Pairs with ignored traffic in between.
    localparam int N_RESEND      = 16;  // Pairs under random resend stretches.
    localparam int N_ROUTE       = 3;
    localparam int ROUTE_PAIRS   = 4;
    localparam int MAX_IN_FLIGHT = `LEAF_FIFO_DEPTH - 2;
    localparam int STIM_CYCLES   = 16 + 6 + 3 * N_BASIC + 2 * N_RESEND
                                 + N_ROUTE * (3 + 2 * ROUTE_PAIRS) + 4 * `LEAF_FIFO_DEPTH + 20;

    logic                           clk;
    logic                           arst_n;
    logic                           resend;
    logic [`LEAF_PACKET_BITS-1:0]   din;
    logic [`LEAF_PACKET_BITS-1:0]   dout;
    logic [31:0]                    rng_state;
    logic [`LEAF_PACKET_BITS-1:0]   exp_q1 [$];  // Sums for output port 1.
    logic [`LEAF_PACKET_BITS-1:0]   exp_q2 [$];  // Differences for output port 2.
    logic [`LEAF_NUM_LEAF_BITS-1:0] route_leaf [1:2];
    logic [`LEAF_NUM_PORT_BITS-1:0] route_port [1:2];
    logic                           resend_mode;
    logic                           data_started;
    int                             resend_left;
    int                             pairs_sent;
    int                             out_count;

    leaf_top #(.LEAF_ID(LEAF_ID)) UUT (
        .clk(clk), .arst_n(arst_n),
        .din_leaf_bft2interface(din),
        .dout_leaf_interface2bft(dout),
        .resend(resend)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic abort_run();
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // The tag is ignored on receive, so it carries junk here.
    function automatic logic [`LEAF_PACKET_BITS-1:0] data_packet(input logic [3:0] port,
                                                                input logic [31:0] word);
        return {1'b1, LEAF_ID, port, word[6:0] ^ 7'h55, word};
    endfunction

    function automatic logic [`LEAF_PACKET_BITS-1:0] expected_packet(input int p,
                                                                    input logic [31:0] word);
        return {1'b1, route_leaf[p], route_port[p], 7'd0, word};
    endfunction

    // ####################
    // Ignored traffic
    // ####################

    function automatic logic [`LEAF_PACKET_BITS-1:0] noise_packet(input logic [31:0] r);
        logic [`LEAF_NUM_LEAF_BITS-1:0] leaf;
        logic [`LEAF_PACKET_BITS-1:0]   pkt;
        leaf = (r[6:2] == LEAF_ID) ? r[6:2] ^ 5'd1 : r[6:2];
        case (r[8:7])
            2'd0:    pkt = {1'b1, leaf, r[12:9], 7'd0, r};               // Another leaf.
            2'd1:    pkt = {1'b0, LEAF_ID, 2'd0, r[10:9], 7'd0, r};      // Valid bit clear.
            default: pkt = {1'b1, LEAF_ID, 4'd3 + (r[12:9] % 4'd13), 7'd0, r};
        endcase
        return pkt;
    endfunction

    // One clock of stimulus; resend flips in random stretches while enabled.
    task automatic drive_cycle(input logic [`LEAF_PACKET_BITS-1:0] word);
        logic [31:0] r;
        @(posedge clk);
        din <= word;
        if (!resend_mode) begin
            resend <= 1'b0;
        end else if (resend_left == 0) begin
            r = next_random();
            resend <= ~resend;
            resend_left = 1 + int'(r[3:0]);
        end else begin
            resend_left--;
        end
    endtask

    // Keeps the input buffers below their depth.
    task automatic wait_room();
        while (exp_q1.size() > MAX_IN_FLIGHT) drive_cycle('0);
    endtask

    task automatic wait_idle();
        while (exp_q1.size() != 0 || exp_q2.size() != 0) drive_cycle('0);
    endtask

    task automatic expect_pair(input logic [31:0] w1, input logic [31:0] w2);
        exp_q1.push_back(expected_packet(1, w1 + w2));
        exp_q2.push_back(expected_packet(2, w1 - w2));
        pairs_sent++;
    endtask

    // Port 1 routes stay below leaf 16 and port 2 routes above, so the leaf MSB names the port.
    task automatic send_config(input int p);
        logic [31:0] r;
        r = next_random();
        wait_idle();
        route_leaf[p] = {p == 2, r[3:0]};
        route_port[p] = r[7:4];
        drive_cycle({1'b1, LEAF_ID, 4'd0, 7'd0, 4'(p), route_leaf[p], route_port[p], 19'd0});
        drive_cycle('0);
        drive_cycle('0);
    endtask

    task automatic send_pair(input bit noise);
        logic [31:0] w1;
        logic [31:0] w2;
        logic [31:0] r;
        wait_room();
        w1 = next_random();
        w2 = next_random();
        r  = next_random();
        drive_cycle(data_packet(r[0] ? 4'd2 : 4'd1, r[0] ? w2 : w1));
        data_started <= 1'b1;
        if (noise) drive_cycle(noise_packet(r));
        drive_cycle(data_packet(r[0] ? 4'd1 : 4'd2, r[0] ? w1 : w2));
        expect_pair(w1, w2);
    endtask

    task automatic send_burst(input int len, input bit port_2_first);
        logic [31:0] w1 [`LEAF_FIFO_DEPTH];
        logic [31:0] w2 [`LEAF_FIFO_DEPTH];
        wait_idle();
        for (int i = 0; i < len; i++) begin
            w1[i] = next_random();
            w2[i] = next_random();
        end
        for (int i = 0; i < len; i++) begin
            drive_cycle(port_2_first ? data_packet(4'd2, w2[i]) : data_packet(4'd1, w1[i]));
        end
        for (int i = 0; i < len; i++) begin
            drive_cycle(port_2_first ? data_packet(4'd1, w1[i]) : data_packet(4'd2, w2[i]));
            expect_pair(w1[i], w2[i]);
        end
    endtask

    // ####################
    // Output checks
    // ####################

    // Without a valid packet, before the first data word and during resend the output is zero.
    always @(negedge clk) begin
        logic [`LEAF_PACKET_BITS-1:0] head;
        int                           left;
        if (arst_n && (!data_started || resend || !dout[48])) begin
            a_idle_zero: assert (dout == '0) else begin
                $display("MISMATCH dout_leaf_interface2bft expected %h actual %h", 49'h0, dout);
                abort_run();
            end
        end else if (arst_n) begin
            out_count++;
            left = dout[47] ? exp_q2.size() : exp_q1.size();
            if (left == 0) begin
                $display("packet %h arrived while nothing was expected on its port", dout);
                abort_run();
            end else begin
                head = dout[47] ? exp_q2[0] : exp_q1[0];
                a_match: assert (dout == head) begin
                    if (dout[47]) void'(exp_q2.pop_front());
                    else void'(exp_q1.pop_front());
                end else begin
                    $display("MISMATCH dout_leaf_interface2bft expected %h actual %h", head, dout);
                    abort_run();
                end
            end
        end
    end

    initial begin
        repeat (20 * STIM_CYCLES + 1000) @(posedge clk);
        $display("watchdog expired with %0d and %0d packets still expected",
                 exp_q1.size(), exp_q2.size());
        abort_run();
    end

    initial begin
        arst_n       = 1'b0;
        resend       = 1'b0;
        din          = '0;
        rng_state    = 32'hf4285c63;
        resend_mode  = 1'b0;
        data_started = 1'b0;
        resend_left  = 0;
        pairs_sent   = 0;
        out_count    = 0;
        repeat (16) @(posedge clk);
        arst_n <= 1'b1;
        repeat (4) drive_cycle('0);

        send_config(1);
        send_config(2);
        for (int i = 0; i < N_BASIC; i++) send_pair(1'b1);

        resend_mode = 1'b1;
        for (int i = 0; i < N_RESEND; i++) send_pair(1'b0);
        resend_mode = 1'b0;

        // Each new route only applies to pairs sent after it.
        for (int i = 0; i < N_ROUTE; i++) begin
            send_config(1 + i % 2);
            for (int j = 0; j < ROUTE_PAIRS; j++) send_pair((j % 2) == 1);
        end

        send_burst(`LEAF_FIFO_DEPTH, 1'b0);
        send_burst(1 + int'(next_random() % 8), 1'b1);

        wait_idle();
        repeat (20) drive_cycle('0);
        if (out_count == 2 * pairs_sent) begin
            $display("TEST PASSED");
            $finish;
        end else begin
            $display("MISMATCH out_count expected %h actual %h", 2 * pairs_sent, out_count);
            abort_run();
        end
    end

endmodule

`default_nettype wire

// File: build.f
+incdir+.
leaf_pkg.sv
leaf_rx_decoder.sv
leaf_port_fifo.sv
leaf_user_kernel.sv
leaf_tx_packetizer.sv
leaf_top.sv
tb_leaf_top.sv

// File: Makefile
TOP := tb_leaf_top

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

obj_dir/V$(TOP): build.f $(wildcard *.sv *.svh)
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f build.f

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f build.f

clean:
	rm -rf obj_dir
